//--- flist.f
verilog/vc_alloc_pkg.sv
verilog/rr_arbiter.sv
verilog/sw_alloc_stage.sv
verilog/spec_sw_alloc.sv
verilog/spec_vc_alloc.sv
verilog/comb_spec_allocator.sv
testbench/alloc_asserts.sv
testbench/alloc_tb.sv

//--- run.sh
#!/bin/sh
# build and run the allocator testbench, exit status is the verdict
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module alloc_tb -f flist.f -o alloc_sim

./obj_dir/alloc_sim

//--- testbench/alloc_tb.sv
module alloc_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int np          = vc_alloc_pkg::num_ports;
    localparam int nv          = vc_alloc_pkg::num_vcs;
    localparam int nd          = vc_alloc_pkg::num_dst;
    localparam int grp_ns_in   = 0; // output arbiters of a stage sit at in group + 1
    localparam int grp_sp_in   = 2;
    localparam int grp_ovc     = 4;
    localparam int mode_nonspec = 0;
    localparam int mode_spec    = 1;
    localparam int mode_mixed   = 2;

    logic                               clk;
    logic                               rst_n;
    vc_alloc_pkg::port_req_t   [np-1:0] req;
    vc_alloc_pkg::port_grant_t [np-1:0] grant;
    vc_alloc_pkg::vc_vec_t     [np-1:0] ovc_allocated;

    vc_alloc_pkg::port_grant_t [np-1:0] exp_grant;
    vc_alloc_pkg::vc_vec_t     [np-1:0] exp_alloc;
    int          ptr      [5][np]; // model pointers by group and port
    logic [3:0]  snap_req [5][np];
    logic [3:0]  snap_gnt [5][np];
    logic [31:0] lfsr_state = 32'h0b70_07bc;
    int          errors     = 0;
    int          cycle_no   = 0;

    comb_spec_allocator dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .req           (req),
        .grant         (grant),
        .ovc_allocated (ovc_allocated)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic int other_port(int self, int k);
        return (k >= self) ? k + 1 : k;
    endfunction

    function automatic int dst_bit(int self, int port);
        return (port > self) ? port - 1 : port;
    endfunction

    // first requester at or after p in a 4-wide arbiter
    function automatic logic [3:0] rr_pick(logic [3:0] r, int p);
        logic [3:0] g;
        g = '0;
        for (int k = 0; k < 4; k++) begin
            if (r[(p + k) % 4] && !(|g)) begin
                g[(p + k) % 4] = 1'b1;
            end
        end
        return g;
    endfunction

    task automatic abort_run();
        $display("Something failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(string name, logic [127:0] expected, logic [127:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic arbitrate(int grp, int p, logic [3:0] r, output logic [3:0] g);
        g = rr_pick(r, ptr[grp][p]);
        snap_req[grp][p] = r;
        snap_gnt[grp][p] = g;
    endtask

    task automatic reset_model();
        for (int g = 0; g < 5; g++) begin
            for (int p = 0; p < np; p++) begin
                ptr[g][p]      = 0;
                snap_req[g][p] = '0;
                snap_gnt[g][p] = '0;
            end
        end
    endtask

    // winner drops to lowest priority
    task automatic advance_model();
        for (int g = 0; g < 5; g++) begin
            for (int p = 0; p < np; p++) begin
                for (int k = 0; k < 4; k++) begin
                    if (snap_gnt[g][p][k]) begin
                        ptr[g][p] = (k + 1) % 4;
                    end
                end
            end
        end
    endtask

    task automatic model_stage(int grp, vc_alloc_pkg::vc_vec_t [np-1:0] reqv,
                               output vc_alloc_pkg::vc_vec_t  [np-1:0] win,
                               output vc_alloc_pkg::dst_vec_t [np-1:0] dgr,
                               output logic [np-1:0] in_g,
                               output logic [np-1:0] out_g);
        vc_alloc_pkg::dst_vec_t [np-1:0] wdest;
        logic [3:0] oreq;
        logic [3:0] ogr;
        logic [3:0] w;
        dgr = '0;
        for (int i = 0; i < np; i++) begin
            arbitrate(grp, i, reqv[i], w);
            win[i]   = w;
            wdest[i] = '0;
            for (int v = 0; v < nv; v++) begin
                if (w[v]) begin
                    wdest[i] = req[i].dest[v];
                end
            end
        end
        for (int o = 0; o < np; o++) begin
            for (int k = 0; k < nd; k++) begin
                oreq[k] = wdest[other_port(o, k)][dst_bit(other_port(o, k), o)];
            end
            arbitrate(grp + 1, o, oreq, ogr);
            out_g[o] = |oreq;
            for (int k = 0; k < nd; k++) begin
                if (ogr[k]) begin
                    dgr[other_port(o, k)][dst_bit(other_port(o, k), o)] = 1'b1;
                end
            end
        end
        for (int i = 0; i < np; i++) begin
            in_g[i] = |dgr[i];
        end
    endtask

    task automatic compute_expected();
        vc_alloc_pkg::vc_vec_t  [np-1:0] ns_req;
        vc_alloc_pkg::vc_vec_t  [np-1:0] sp_req;
        vc_alloc_pkg::vc_vec_t  [np-1:0] ns_win;
        vc_alloc_pkg::vc_vec_t  [np-1:0] sp_win;
        vc_alloc_pkg::dst_vec_t [np-1:0] ns_dgr;
        vc_alloc_pkg::dst_vec_t [np-1:0] sp_dgr;
        logic [np-1:0] ns_in;
        logic [np-1:0] ns_out;
        logic [np-1:0] sp_in;
        logic [np-1:0] sp_out;
        logic [3:0]    cand;
        logic [3:0]    pick;
        logic [3:0]    acc;
        for (int i = 0; i < np; i++) begin
            ns_req[i] = req[i].vc_request & req[i].ovc_assigned & req[i].ovc_not_full;
            sp_req[i] = req[i].vc_request & ~req[i].ovc_assigned;
        end
        model_stage(grp_ns_in, ns_req, ns_win, ns_dgr, ns_in, ns_out);
        model_stage(grp_sp_in, sp_req, sp_win, sp_dgr, sp_in, sp_out);
        exp_alloc = '0;
        for (int i = 0; i < np; i++) begin
            cand = '0;
            for (int v = 0; v < nv; v++) begin
                if (sp_win[i][v]) begin
                    cand = req[i].cand_ovc[v];
                end
            end
            arbitrate(grp_ovc, i, cand, pick);
            for (int d = 0; d < nd; d++) begin  // spec grant survives only on free input and output
                acc[d] = sp_dgr[i][d] && !ns_in[i] && !ns_out[other_port(i, d)] && (|cand);
            end
            exp_grant[i].sw_grant      = ns_in[i] ? ns_win[i] : '0;
            exp_grant[i].dest_grant    = ns_dgr[i] | acc;
            exp_grant[i].ovc_grant_ivc = '0;
            exp_grant[i].granted_ovc   = '0;
            if (|acc) begin
                exp_grant[i].sw_grant      = exp_grant[i].sw_grant | sp_win[i];
                exp_grant[i].ovc_grant_ivc = sp_win[i];
                exp_grant[i].granted_ovc   = pick;
                for (int d = 0; d < nd; d++) begin
                    if (acc[d]) begin
                        exp_alloc[other_port(i, d)] = exp_alloc[other_port(i, d)] | pick;
                    end
                end
            end
        end
    endtask

    task automatic drive_random_req(int mode);
        for (int i = 0; i < np; i++) begin
            req[i].vc_request   = vc_alloc_pkg::vc_vec_t'(rand_bits(nv));
            req[i].ovc_assigned = (mode == mode_nonspec) ? '1 :
                                  (mode == mode_spec) ? '0 : vc_alloc_pkg::vc_vec_t'(rand_bits(nv));
            req[i].ovc_not_full = vc_alloc_pkg::vc_vec_t'(rand_bits(nv));
            for (int v = 0; v < nv; v++) begin
                req[i].dest[v]     = vc_alloc_pkg::dst_vec_t'(1) << rand_bits($clog2(nd));
                req[i].cand_ovc[v] = vc_alloc_pkg::vc_vec_t'(rand_bits(nv));
            end
        end
    endtask

    // all vcs of port 0 toward port 1
    task automatic drive_fairness_req();
        req = '0;
        req[0].vc_request   = '1;
        req[0].ovc_assigned = '1;
        req[0].ovc_not_full = '1;
        for (int v = 0; v < nv; v++) begin
            req[0].dest[v] = vc_alloc_pkg::dst_vec_t'(1 << dst_bit(0, 1));
        end
    endtask

    task automatic step_and_check(string name, int mode);
        string tag;
        tag = $sformatf("%s cycle %0d", name, cycle_no);
        compute_expected();
        check_value({tag, " grant"}, 128'(exp_grant), 128'(grant));
        check_value({tag, " ovc_allocated"}, 128'(exp_alloc), 128'(ovc_allocated));
        for (int i = 0; i < np; i++) begin
            if (mode == mode_nonspec) begin
                check_value({tag, " full ovc granted"}, 128'(0),
                            128'(grant[i].sw_grant & ~req[i].ovc_not_full));
            end
            for (int v = 0; v < nv; v++) begin
                if (mode == mode_spec && grant[i].sw_grant[v]) begin
                    check_value({tag, " empty cand_ovc"}, 128'(1), 128'(|req[i].cand_ovc[v]));
                end
            end
        end
        @(posedge clk);
        advance_model();
        cycle_no++;
    endtask

    // reset held over five rising edges, released on a falling edge
    task automatic apply_reset();
        rst_n = 1'b0;
        req   = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        reset_model();
    endtask

    task automatic wait_idle(int limit);
        int n;
        n = 0;
        while (grant != '0 || ovc_allocated != '0) begin
            if (n >= limit) begin
                $display("timeout: grant outputs stayed non-zero after reset");
                abort_run();
            end
            @(negedge clk);
            n++;
        end
    endtask

    task automatic run_random(string name, int mode, int cycles);
        for (int c = 0; c < cycles; c++) begin
            @(negedge clk);
            drive_random_req(mode);
            #5;
            step_and_check(name, mode);
        end
    endtask

    initial begin
        rst_n = 1'b0;
        req   = '0;
        apply_reset();
        wait_idle(10);
        for (int c = 0; c < 4; c++) begin
            @(negedge clk);
            req = '0;
            #5;
            check_value("idle grant", 128'(0), 128'(grant));
            step_and_check("idle", mode_mixed);
        end

        run_random("nonspec", mode_nonspec, 300);
        run_random("spec", mode_spec, 300);
        run_random("mixed", mode_mixed, 2000);

        @(negedge clk);
        apply_reset(); // pointers back to vc 0
        for (int c = 0; c < nv; c++) begin
            @(negedge clk);
            drive_fairness_req();
            #5;
            check_value($sformatf("fairness rotation %0d", c), 128'(4'b0001 << c),
                        128'(grant[0].sw_grant));
            step_and_check("fairness", mode_nonspec);
        end

        if (errors == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule

//--- testbench/alloc_asserts.sv
module alloc_asserts (
    input logic                                                    clk,
    input logic                                                    rst_n,
    input vc_alloc_pkg::port_grant_t [vc_alloc_pkg::num_ports-1:0] grant
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int np = vc_alloc_pkg::num_ports;
    localparam int nd = vc_alloc_pkg::num_dst;

    // true when some output is granted to more than one input
    function automatic logic output_shared(vc_alloc_pkg::port_grant_t [np-1:0] g);
        int   users [np];
        int   o;
        logic shared;
        shared = 1'b0;
        for (int p = 0; p < np; p++) begin
            users[p] = 0;
        end
        for (int i = 0; i < np; i++) begin
            for (int d = 0; d < nd; d++) begin
                if (g[i].dest_grant[d]) begin
                    o = (d >= i) ? d + 1 : d; // own port skipped
                    users[o]++;
                end
            end
        end
        for (int p = 0; p < np; p++) begin
            if (users[p] > 1) begin
                shared = 1'b1;
            end
        end
        return shared;
    endfunction

    for (genvar i = 0; i < np; i++) begin : g_port
        sw_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
            $onehot0(grant[i].sw_grant))
            else $error("port %0d has more than one vc on the crossbar", i);

        dest_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
            $onehot0(grant[i].dest_grant))
            else $error("port %0d is granted more than one output", i);

        new_ovc_needs_switch: assert property (@(posedge clk) disable iff (!rst_n)
            (grant[i].ovc_grant_ivc & ~grant[i].sw_grant) == '0)
            else $error("port %0d got an output vc without a switch grant", i);
    end

    output_not_shared: assert property (@(posedge clk) disable iff (!rst_n)
        !output_shared(grant))
        else $error("two inputs granted the same output");

endmodule

bind comb_spec_allocator alloc_asserts asserts_i (
    .clk   (clk),
    .rst_n (rst_n),
    .grant (grant)
);

//--- verilog/comb_spec_allocator.sv
module comb_spec_allocator (
    input  logic                                                   clk,
    input  logic                                                   rst_n,
    input  vc_alloc_pkg::port_req_t   [vc_alloc_pkg::num_ports-1:0] req,
    output vc_alloc_pkg::port_grant_t [vc_alloc_pkg::num_ports-1:0] grant,
    output vc_alloc_pkg::vc_vec_t     [vc_alloc_pkg::num_ports-1:0] ovc_allocated
);

    localparam int np = vc_alloc_pkg::num_ports;

    logic                   [np-1:0] spec_valid;
    vc_alloc_pkg::vc_vec_t  [np-1:0] spec_first_win;
    vc_alloc_pkg::dst_vec_t [np-1:0] spec_accepted;  // spec grants that survived
    vc_alloc_pkg::vc_vec_t  [np-1:0] sw_grant;
    vc_alloc_pkg::dst_vec_t [np-1:0] dest_grant;
    vc_alloc_pkg::vc_vec_t  [np-1:0] ovc_grant_ivc;
    vc_alloc_pkg::vc_vec_t  [np-1:0] granted_ovc;

    spec_sw_alloc sw_alloc_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .req            (req),
        .spec_valid     (spec_valid),
        .spec_first_win (spec_first_win),
        .spec_accepted  (spec_accepted),
        .sw_grant       (sw_grant),
        .dest_grant     (dest_grant)
    );

    spec_vc_alloc vc_alloc_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .req            (req),
        .spec_first_win (spec_first_win),
        .spec_accepted  (spec_accepted),
        .spec_valid     (spec_valid),
        .ovc_grant_ivc  (ovc_grant_ivc),
        .granted_ovc    (granted_ovc),
        .ovc_allocated  (ovc_allocated)
    );

    always_comb begin
        for (int i = 0; i < np; i++) begin
            grant[i].sw_grant      = sw_grant[i];
            grant[i].dest_grant    = dest_grant[i];
            grant[i].ovc_grant_ivc = ovc_grant_ivc[i];
            grant[i].granted_ovc   = granted_ovc[i];
        end
    end

endmodule

//--- verilog/spec_vc_alloc.sv
module spec_vc_alloc (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    input  vc_alloc_pkg::port_req_t [vc_alloc_pkg::num_ports-1:0] req,
    input  vc_alloc_pkg::vc_vec_t   [vc_alloc_pkg::num_ports-1:0] spec_first_win,
    input  vc_alloc_pkg::dst_vec_t  [vc_alloc_pkg::num_ports-1:0] spec_accepted,
    output logic                    [vc_alloc_pkg::num_ports-1:0] spec_valid,
    output vc_alloc_pkg::vc_vec_t   [vc_alloc_pkg::num_ports-1:0] ovc_grant_ivc,
    output vc_alloc_pkg::vc_vec_t   [vc_alloc_pkg::num_ports-1:0] granted_ovc,
    output vc_alloc_pkg::vc_vec_t   [vc_alloc_pkg::num_ports-1:0] ovc_allocated
);

    localparam int np = vc_alloc_pkg::num_ports;
    localparam int nv = vc_alloc_pkg::num_vcs;
    localparam int nd = vc_alloc_pkg::num_dst;

    vc_alloc_pkg::vc_vec_t      [np-1:0] cand;     // candidate ovcs of the spec winner
    wire vc_alloc_pkg::vc_vec_t [np-1:0] pick;     // one ovc per input port
    wire                        [np-1:0] found;
    logic                       [np-1:0] accepted;

    always_comb begin
        for (int i = 0; i < np; i++) begin
            cand[i] = '0;
            for (int v = 0; v < nv; v++) begin
                if (spec_first_win[i][v]) begin
                    cand[i] = cand[i] | req[i].cand_ovc[v];
                end
            end
        end
    end

    for (genvar i = 0; i < np; i++) begin : g_ovc_arb
        rr_arbiter #(
            .width     (nv)
        ) ovc_arb (
            .clk       (clk),
            .rst_n     (rst_n),
            .request   (cand[i]),
            .grant     (pick[i]),
            .any_grant (found[i])
        );
    end

    // independent of acceptance, keeps the loop through spec_sw_alloc open
    assign spec_valid = found;

    always_comb begin
        ovc_allocated = '0;
        for (int i = 0; i < np; i++) begin
            accepted[i]      = |spec_accepted[i];
            ovc_grant_ivc[i] = accepted[i] ? spec_first_win[i] : '0;
            granted_ovc[i]   = accepted[i] ? pick[i] : '0;
            for (int d = 0; d < nd; d++) begin
                if (spec_accepted[i][d]) begin
                    // mark at the absolute output port
                    ovc_allocated[vc_alloc_pkg::dst_to_port(i, d)] =
                        ovc_allocated[vc_alloc_pkg::dst_to_port(i, d)] | pick[i];
                end
            end
        end
    end

endmodule

//--- verilog/spec_sw_alloc.sv
module spec_sw_alloc (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    input  vc_alloc_pkg::port_req_t [vc_alloc_pkg::num_ports-1:0] req,
    input  logic                    [vc_alloc_pkg::num_ports-1:0] spec_valid,
    output vc_alloc_pkg::vc_vec_t   [vc_alloc_pkg::num_ports-1:0] spec_first_win,
    output vc_alloc_pkg::dst_vec_t  [vc_alloc_pkg::num_ports-1:0] spec_accepted,
    output vc_alloc_pkg::vc_vec_t   [vc_alloc_pkg::num_ports-1:0] sw_grant,
    output vc_alloc_pkg::dst_vec_t  [vc_alloc_pkg::num_ports-1:0] dest_grant
);

    localparam int np = vc_alloc_pkg::num_ports;
    localparam int nv = vc_alloc_pkg::num_vcs;
    localparam int nd = vc_alloc_pkg::num_dst;

    vc_alloc_pkg::vc_vec_t   [np-1:0]         nonspec_req;
    vc_alloc_pkg::vc_vec_t   [np-1:0]         spec_req;
    vc_alloc_pkg::dst_vec_t  [np-1:0][nv-1:0] req_dest;
    vc_alloc_pkg::sw_stage_t [np-1:0]         nonspec_res;
    vc_alloc_pkg::sw_stage_t [np-1:0]         spec_res;
    logic                    [np-1:0]         nonspec_in_granted;
    logic                    [np-1:0]         nonspec_out_granted;
    vc_alloc_pkg::dst_vec_t  [np-1:0]         spec_ok; // outputs a spec grant may keep

    always_comb begin
        for (int i = 0; i < np; i++) begin
            // full output vc masks only the non-spec side
            nonspec_req[i] = req[i].vc_request & req[i].ovc_assigned & req[i].ovc_not_full;
            spec_req[i]    = req[i].vc_request & ~req[i].ovc_assigned;
            req_dest[i]    = req[i].dest;
        end
    end

    sw_alloc_stage nonspec_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .request     (nonspec_req),
        .dest        (req_dest),
        .result      (nonspec_res),
        .in_granted  (nonspec_in_granted),
        .out_granted (nonspec_out_granted)
    );

    sw_alloc_stage spec_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .request     (spec_req),
        .dest        (req_dest),
        .result      (spec_res),
        .in_granted  (),
        .out_granted ()
    );

    // spec winners feed the vc allocator ahead of acceptance
    always_comb begin
        for (int i = 0; i < np; i++) begin
            spec_first_win[i] = spec_res[i].first_win;
        end
    end

    always_comb begin
        for (int i = 0; i < np; i++) begin
            for (int d = 0; d < nd; d++) begin
                spec_ok[i][d] = ~nonspec_out_granted[vc_alloc_pkg::dst_to_port(i, d)];
            end
            // input busy with a non-spec grant, or no output vc found
            if (nonspec_in_granted[i] || !spec_valid[i]) begin
                spec_ok[i] = '0;
            end

            spec_accepted[i] = spec_res[i].dest_grant & spec_ok[i];

            sw_grant[i] = nonspec_res[i].sw_grant;
            if (|spec_accepted[i]) begin
                sw_grant[i] = sw_grant[i] | spec_res[i].sw_grant;
            end
            dest_grant[i] = nonspec_res[i].dest_grant | spec_accepted[i];
        end
    end

endmodule

//--- verilog/sw_alloc_stage.sv
module sw_alloc_stage (
    input  logic                                               clk,
    input  logic                                               rst_n,
    input  vc_alloc_pkg::vc_vec_t   [vc_alloc_pkg::num_ports-1:0] request,
    input  vc_alloc_pkg::dst_vec_t  [vc_alloc_pkg::num_ports-1:0][vc_alloc_pkg::num_vcs-1:0]
                                                                  dest,
    output vc_alloc_pkg::sw_stage_t [vc_alloc_pkg::num_ports-1:0] result,
    output logic                    [vc_alloc_pkg::num_ports-1:0] in_granted,
    output logic                    [vc_alloc_pkg::num_ports-1:0] out_granted
);

    localparam int np = vc_alloc_pkg::num_ports;
    localparam int nv = vc_alloc_pkg::num_vcs;
    localparam int nd = vc_alloc_pkg::num_dst;

    wire vc_alloc_pkg::vc_vec_t  [np-1:0] first_win;  // input arbiter winners
    vc_alloc_pkg::dst_vec_t      [np-1:0] win_dest;   // destination of each winner

    // per output, bit k is the k-th other input in ascending order
    wire vc_alloc_pkg::dst_vec_t [np-1:0] out_req;
    wire vc_alloc_pkg::dst_vec_t [np-1:0] out_grant;

    // per input, back in the skipped-own-port index
    wire vc_alloc_pkg::dst_vec_t [np-1:0] dest_grant;
    wire                         [np-1:0] out_any;

    // input arbiters, one vc per port
    for (genvar i = 0; i < np; i++) begin : g_in_arb
        rr_arbiter #(
            .width     (nv)
        ) in_arb (
            .clk       (clk),
            .rst_n     (rst_n),
            .request   (request[i]),
            .grant     (first_win[i]),
            .any_grant ()
        );
    end

    // dest of the winning vc
    always_comb begin
        for (int i = 0; i < np; i++) begin
            win_dest[i] = '0;
            for (int v = 0; v < nv; v++) begin
                if (first_win[i][v]) begin
                    win_dest[i] = win_dest[i] | dest[i][v];
                end
            end
        end
    end

    for (genvar o = 0; o < np; o++) begin : g_out
        for (genvar k = 0; k < nd; k++) begin : g_src
            localparam int src     = vc_alloc_pkg::dst_to_port(o, k);
            localparam int src_bit = vc_alloc_pkg::port_to_dst(src, o);

            assign out_req[o][k]            = win_dest[src][src_bit];
            assign dest_grant[src][src_bit] = out_grant[o][k]; // same pairing on the way back
        end

        rr_arbiter #(
            .width     (nd)
        ) out_arb (
            .clk       (clk),
            .rst_n     (rst_n),
            .request   (out_req[o]),
            .grant     (out_grant[o]),
            .any_grant (out_any[o])
        );
    end

    always_comb begin
        for (int i = 0; i < np; i++) begin
            in_granted[i]        = |dest_grant[i];
            result[i].first_win  = first_win[i];
            result[i].dest_grant = dest_grant[i];
            result[i].sw_grant   = in_granted[i] ? first_win[i] : '0;
        end
    end

    assign out_granted = out_any;

endmodule

//--- verilog/rr_arbiter.sv
module rr_arbiter #(
    parameter int width = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [width-1:0] request,
    output logic [width-1:0] grant,
    output logic             any_grant
);

    localparam int ptr_w = (width > 1) ? $clog2(width) : 1;

    logic [ptr_w-1:0] ptr;     // highest priority index
    logic [ptr_w-1:0] win_idx;

    // first requester at or after ptr, wrapping around
    always_comb begin
        int  idx;
        logic found;
        grant   = '0;
        win_idx = '0;
        found   = 1'b0;
        for (int k = 0; k < width; k++) begin
            idx = (int'(ptr) + k) % width;
            if (request[idx] && !found) begin
                grant[idx] = 1'b1;
                win_idx    = ptr_w'(idx);
                found      = 1'b1;
            end
        end
    end

    assign any_grant = |request;

    // winner gets lowest priority next cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (any_grant) begin
            if (int'(win_idx) == width - 1) begin
                ptr <= '0;
            end else begin
                ptr <= win_idx + 1'b1;
            end
        end
    end

endmodule

//--- verilog/vc_alloc_pkg.sv
package vc_alloc_pkg;

    localparam int num_ports = 5;
    localparam int num_vcs   = 4;
    localparam int num_dst   = num_ports - 1; // a port never requests itself

    typedef logic [num_vcs-1:0] vc_vec_t;  // one bit per vc of a port
    typedef logic [num_dst-1:0] dst_vec_t; // one-hot, own port skipped

    typedef struct packed {
        vc_vec_t                vc_request;   // flit waiting
        vc_vec_t                ovc_assigned; // already holds an output vc
        vc_vec_t                ovc_not_full; // held output vc has space
        dst_vec_t [num_vcs-1:0] dest;         // destination per vc
        vc_vec_t  [num_vcs-1:0] cand_ovc;     // free output vcs, unassigned vcs only
    } port_req_t;

    typedef struct packed {
        vc_vec_t  sw_grant;
        dst_vec_t dest_grant;
        vc_vec_t  ovc_grant_ivc;
        vc_vec_t  granted_ovc;
    } port_grant_t;

    typedef struct packed {
        vc_vec_t  first_win;
        dst_vec_t dest_grant;
        vc_vec_t  sw_grant;
    } sw_stage_t;

    // destination bit d of port src to absolute port number
    function automatic int dst_to_port(int src, int d);
        return (d < src) ? d : d + 1;
    endfunction

    // absolute port number to destination bit of port src
    function automatic int port_to_dst(int src, int port);
        return (port < src) ? port : port - 1;
    endfunction

endpackage
